// ==== logic/gpio_pkg.sv ====
// shared definitions for the GPIO subsystem
// widths, register map, control FSM states, AXI4-Lite channel structs

`default_nettype none

package gpio_pkg;

  /////////////////////////////////////////////////////////////////////
  // widths
  /////////////////////////////////////////////////////////////////////

  // controlled GPIO bits, also the AXI4-Lite data width
  localparam int unsigned gpio_w = 32;
  // board pads, upper ones are unused
  localparam int unsigned pad_w = 41;
  // reset synchronizer depth
  localparam int unsigned rst_sync_depth = 4;
  // register address width
  localparam int unsigned axil_addr_w = 8;

  // AXI response code, only OKAY is ever returned
  localparam logic [1:0] axil_resp_okay = 2'b00;

  /////////////////////////////////////////////////////////////////////
  // register map and control states
  /////////////////////////////////////////////////////////////////////

  typedef enum logic [axil_addr_w-1:0] {
    reg_out      = 8'h00,
    reg_oe       = 8'h04,
    // read only, synchronized pads
    reg_in       = 8'h08,
    reg_irq_en   = 8'h0C,
    // write one to clear
    reg_irq_stat = 8'h10
  } gpio_reg_e;

  typedef enum logic [1:0] {
    st_idle,
    st_wresp,
    st_rresp
  } axil_state_e;

  /////////////////////////////////////////////////////////////////////
  // AXI4-Lite channels
  /////////////////////////////////////////////////////////////////////

  // master to slave
  typedef struct packed {
    logic                   awvalid;
    logic [axil_addr_w-1:0] awaddr;
    logic                   wvalid;
    logic [gpio_w-1:0]      wdata;
    logic                   bready;
    logic                   arvalid;
    logic [axil_addr_w-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [gpio_w-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

endpackage : gpio_pkg

`default_nettype wire

// ==== logic/reset_sync.sv ====
// reset synchronizer
// asynchronous assertion, release after rst_sync_depth clock edges

`timescale 1ns/10ps
`default_nettype none

module reset_sync import gpio_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  output logic rst_n
);

// shift chain, all zero while board reset is low
logic [rst_sync_depth-1:0] sync_q;

// ones enter at bit 0 and walk up the chain
// internal reset drops at once, rises on the last stage
always_ff @(posedge clk or negedge arst_n) begin
  if (!arst_n) begin
    sync_q <= '0;
  end else begin
    sync_q <= {sync_q[rst_sync_depth-2:0], 1'b1};
  end
end

// last stage drives the core reset
assign rst_n = sync_q[rst_sync_depth-1];

endmodule : reset_sync

`default_nettype wire

// ==== logic/gpio_input_sync.sv ====
// pad input synchronizer
// two flop stages per bit, cleared by reset

`timescale 1ns/10ps
`default_nettype none

module gpio_input_sync import gpio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [gpio_w-1:0] pad_in,
  output logic [gpio_w-1:0] gpio_in
);

// first stage, may go metastable
logic [gpio_w-1:0] meta_q;

// pads are not related to clk at all
// second stage gives a full cycle to settle
always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    meta_q  <= '0;
    gpio_in <= '0;
  end else begin
    meta_q  <= pad_in;
    gpio_in <= meta_q;
  end
end

// a pad change shows on gpio_in two edges later
// nothing downstream should look at meta_q

endmodule : gpio_input_sync

`default_nettype wire

// ==== logic/gpio_event_detect.sv ====
// rising edge detector on synchronized GPIO inputs
// sticky interrupt status with write-one-to-clear
// registered interrupt line, OR of all status bits

`timescale 1ns/10ps
`default_nettype none

module gpio_event_detect import gpio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [gpio_w-1:0] gpio_in,
  input  logic [gpio_w-1:0] irq_en,
  input  logic [gpio_w-1:0] irq_clr,
  output logic [gpio_w-1:0] irq_stat,
  output logic              irq
);

/////////////////////////////////////////////////////////////////////
// edge detection
/////////////////////////////////////////////////////////////////////

// previous input value
logic [gpio_w-1:0] gpio_in_q;
// enabled 0 to 1 transitions this cycle
logic [gpio_w-1:0] rise;
// status after clear and set
logic [gpio_w-1:0] stat_nxt;

always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    gpio_in_q <= '0;
  end else begin
    gpio_in_q <= gpio_in;
  end
end

// falling edges are ignored
assign rise = gpio_in & ~gpio_in_q & irq_en;

/////////////////////////////////////////////////////////////////////
// status and interrupt
/////////////////////////////////////////////////////////////////////

// clear first, then set
// a new event wins over a clear in the same cycle
assign stat_nxt = (irq_stat & ~irq_clr) | rise;

always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    irq_stat <= '0;
    irq      <= 1'b0;
  end else begin
    irq_stat <= stat_nxt;
    // registered together with status so both move on the same edge
    irq      <= |stat_nxt;
  end
end

endmodule : gpio_event_detect

`default_nettype wire

// ==== logic/gpio_axil_ctrl.sv ====
// AXI4-Lite slave for the GPIO register block
// one transaction at a time, write wins over read
// holds OUT, OE and IRQ_EN, pulses the IRQ status clear mask

`timescale 1ns/10ps
`default_nettype none

module gpio_axil_ctrl import gpio_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // bus
  input  axil_req_t         axil_req,
  output axil_rsp_t         axil_rsp,
  // GPIO side
  input  logic [gpio_w-1:0] gpio_in,
  input  logic [gpio_w-1:0] irq_stat,
  output logic [gpio_w-1:0] gpio_out,
  output logic [gpio_w-1:0] gpio_oe,
  output logic [gpio_w-1:0] irq_en,
  output logic [gpio_w-1:0] irq_clr
);

/////////////////////////////////////////////////////////////////////
// local signals
/////////////////////////////////////////////////////////////////////

// FSM
axil_state_e state;
axil_state_e state_nxt;

// handshakes taken this cycle
logic wr_go;
logic rd_go;

// decoded addresses
gpio_reg_e wr_addr;
gpio_reg_e rd_addr;

// read path
logic [gpio_w-1:0] rdata_mux;
logic [gpio_w-1:0] rdata_q;

/////////////////////////////////////////////////////////////////////
// handshake and FSM
/////////////////////////////////////////////////////////////////////

// write needs address and data together
assign wr_go = (state == st_idle) && axil_req.awvalid && axil_req.wvalid;
// read only when no write is waiting
assign rd_go = (state == st_idle) && axil_req.arvalid && !(axil_req.awvalid && axil_req.wvalid);

always_comb begin
  state_nxt = state;
  case (state)
    st_idle: begin
      if (wr_go) begin
        state_nxt = st_wresp;
      end else if (rd_go) begin
        state_nxt = st_rresp;
      end
    end
    // hold response until master takes it
    st_wresp: begin
      if (axil_req.bready) begin
        state_nxt = st_idle;
      end
    end
    st_rresp: begin
      if (axil_req.rready) begin
        state_nxt = st_idle;
      end
    end
    default: begin
      state_nxt = st_idle;
    end
  endcase
end

always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    state <= st_idle;
  end else begin
    state <= state_nxt;
  end
end

/////////////////////////////////////////////////////////////////////
// write path
/////////////////////////////////////////////////////////////////////

assign wr_addr = gpio_reg_e'(axil_req.awaddr);

// whole word writes, strobes not supported
always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    gpio_out <= '0;
    gpio_oe  <= '0;
    irq_en   <= '0;
  end else if (wr_go) begin
    case (wr_addr)
      reg_out:    gpio_out <= axil_req.wdata;
      reg_oe:     gpio_oe  <= axil_req.wdata;
      reg_irq_en: irq_en   <= axil_req.wdata;
      // IN is read only, status handled below
      default: begin
      end
    endcase
  end
end

// clear mask only during the write handshake cycle
assign irq_clr = (wr_go && (wr_addr == reg_irq_stat)) ? axil_req.wdata : '0;

/////////////////////////////////////////////////////////////////////
// read path
/////////////////////////////////////////////////////////////////////

assign rd_addr = gpio_reg_e'(axil_req.araddr);

always_comb begin
  case (rd_addr)
    reg_out:      rdata_mux = gpio_out;
    reg_oe:       rdata_mux = gpio_oe;
    reg_in:       rdata_mux = gpio_in;
    reg_irq_en:   rdata_mux = irq_en;
    reg_irq_stat: rdata_mux = irq_stat;
    // unmapped reads zero
    default:      rdata_mux = '0;
  endcase
end

// sampled at address handshake, held through the response
always_ff @(posedge clk) begin
  if (rd_go) begin
    rdata_q <= rdata_mux;
  end
end

/////////////////////////////////////////////////////////////////////
// response channels
/////////////////////////////////////////////////////////////////////

assign axil_rsp.awready = wr_go;
assign axil_rsp.wready  = wr_go;
assign axil_rsp.bvalid  = (state == st_wresp);
assign axil_rsp.bresp   = axil_resp_okay;
assign axil_rsp.arready = rd_go;
assign axil_rsp.rvalid  = (state == st_rresp);
assign axil_rsp.rdata   = rdata_q;
assign axil_rsp.rresp   = axil_resp_okay;

endmodule : gpio_axil_ctrl

`default_nettype wire

// ==== logic/gpio_soc_board.sv ====
// board top for the GPIO subsystem
// clock pass-through, reset and input synchronizers, register block
// pad tristate drivers, unused upper pads left floating

`timescale 1ns/10ps
`default_nettype none

module gpio_soc_board import gpio_pkg::*; (
  // system
  input  logic            clk,
  input  logic            arst_n,
  // register bus
  input  axil_req_t       axil_req,
  output axil_rsp_t       axil_rsp,
  // board pads
  inout  wire [pad_w-1:0] pad,
  output logic            irq
);

/////////////////////////////////////////////////////////////////////
// local signals
/////////////////////////////////////////////////////////////////////

// core clock, a PLL would sit here
logic core_clk;
// synchronized reset
logic rst_n;

// GPIO
logic [gpio_w-1:0] gpio_out;
logic [gpio_w-1:0] gpio_oe;
logic [gpio_w-1:0] gpio_in;
logic [gpio_w-1:0] irq_en;
logic [gpio_w-1:0] irq_clr;
logic [gpio_w-1:0] irq_stat;

assign core_clk = clk;

/////////////////////////////////////////////////////////////////////
// instances
/////////////////////////////////////////////////////////////////////

reset_sync u_reset_sync (.clk(core_clk), .arst_n(arst_n), .rst_n(rst_n));

gpio_input_sync u_input_sync (.clk(core_clk), .rst_n(rst_n),
  .pad_in(pad[gpio_w-1:0]), .gpio_in(gpio_in));

gpio_axil_ctrl u_ctrl (.clk(core_clk), .rst_n(rst_n), .axil_req(axil_req),
  .axil_rsp(axil_rsp), .gpio_in(gpio_in), .irq_stat(irq_stat), .gpio_out(gpio_out),
  .gpio_oe(gpio_oe), .irq_en(irq_en), .irq_clr(irq_clr));

gpio_event_detect u_event (.clk(core_clk), .rst_n(rst_n), .gpio_in(gpio_in),
  .irq_en(irq_en), .irq_clr(irq_clr), .irq_stat(irq_stat), .irq(irq));

/////////////////////////////////////////////////////////////////////
// pads
/////////////////////////////////////////////////////////////////////

// driven bits only where OE is set
for (genvar i = 0; i < gpio_w; i++) begin : g_pad_io
  assign pad[i] = gpio_oe[i] ? gpio_out[i] : 1'bz;
end

// upper pads unused
for (genvar i = gpio_w; i < pad_w; i++) begin : g_pad_nc
  assign pad[i] = 1'bz;
end

endmodule : gpio_soc_board

`default_nettype wire

// ==== tests/gpio_soc_assertions.sv ====
// concurrent checks bound into the AXI4-Lite slave
// response hold, ready only in idle, one response at a time

`timescale 1ns/10ps
`default_nettype none

module gpio_soc_assertions import gpio_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input axil_req_t   axil_req,
  input axil_rsp_t   axil_rsp,
  input axil_state_e state
);

// number of failed checks
int unsigned fail_count = 0;

// write response waits for the master
a_bvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
  axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
  else begin
    fail_count++;
    $error("bvalid dropped before bready");
  end

// read data waits for the master
a_rvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
  axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
  else begin
    fail_count++;
    $error("rvalid dropped before rready");
  end

// new writes only taken in idle
a_wready_idle : assert property (@(posedge clk) disable iff (!rst_n)
  (axil_rsp.awready || axil_rsp.wready) |-> state == st_idle)
  else begin
    fail_count++;
    $error("awready or wready high outside st_idle");
  end

// single open transaction
a_one_rsp : assert property (@(posedge clk) disable iff (!rst_n)
  !(axil_rsp.bvalid && axil_rsp.rvalid))
  else begin
    fail_count++;
    $error("bvalid and rvalid high together");
  end

endmodule : gpio_soc_assertions

`default_nettype wire

// ==== tests/gpio_soc_tb.sv ====
// testbench for the GPIO board top
// AXI4-Lite master tasks, pad model, stimulus table and checks

`timescale 1ns/10ps
`default_nettype none

module gpio_soc_tb import gpio_pkg::*; ();

typedef enum {op_write, op_read, op_pads, op_pad_check, op_irq, op_stall} op_e;
typedef enum {w_aw, w_b, w_ar, w_r} wait_e;

typedef struct {
  string                  name;
  op_e                    op;
  logic [axil_addr_w-1:0] addr;
  logic [pad_w-1:0]       data;
  logic [pad_w-1:0]       exp;
} step_t;

localparam int unsigned wait_limit = 64;

logic              clk;
logic              arst_n;
axil_req_t         axil_req;
axil_rsp_t         axil_rsp;
wire [pad_w-1:0]   pad;
logic              irq;
// pad model, tb drives wherever its own OE copy is zero
logic [pad_w-1:0]  tb_pad_drv;
logic [gpio_w-1:0] tb_oe;

step_t       steps[$];
int unsigned checks = 0;
int unsigned mismatches = 0;
int unsigned timeouts = 0;

gpio_soc_board UUT (.clk(clk), .arst_n(arst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
  .pad(pad), .irq(irq));

bind gpio_axil_ctrl gpio_soc_assertions u_axil_checks (.clk(clk), .rst_n(rst_n),
  .axil_req(axil_req), .axil_rsp(axil_rsp), .state(state));

for (genvar i = 0; i < pad_w; i++) begin : g_pad_model
  if (i < gpio_w) begin : g_io
    assign pad[i] = tb_oe[i] ? 1'bz : tb_pad_drv[i];
  end else begin : g_nc
    assign pad[i] = tb_pad_drv[i];
  end
end

initial begin
  clk = 1'b0;
  forever #5 clk = ~clk;
end

//////////////////////////////////////////////////////////////////////
// helpers and bus tasks
//////////////////////////////////////////////////////////////////////

function automatic logic [pad_w-1:0] rand_pads();
  logic [63:0] r;
  r = {$urandom, $urandom};
  return r[pad_w-1:0];
endfunction

// pad levels seen with the DUT driving OUT under OE and the tb the rest
function automatic logic [pad_w-1:0] pad_expect(input logic [gpio_w-1:0] out_v,
  input logic [gpio_w-1:0] oe_v, input logic [pad_w-1:0] drv);
  logic [pad_w-1:0] res;
  res = drv;
  res[gpio_w-1:0] = (out_v & oe_v) | (drv[gpio_w-1:0] & ~oe_v);
  return res;
endfunction

// address and data are taken together, so both readies must be up
function automatic logic flag_of(input wait_e sel);
  case (sel)
    w_aw:    return axil_rsp.awready && axil_rsp.wready;
    w_b:     return axil_rsp.bvalid;
    w_ar:    return axil_rsp.arready;
    default: return axil_rsp.rvalid;
  endcase
endfunction

task automatic check_equal(input string name, input logic [pad_w-1:0] exp,
  input logic [pad_w-1:0] act);
  checks++;
  assert (act === exp) else begin
    mismatches++;
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
  end
endtask

// sampled on the falling edge, away from the rising edge updates
task automatic wait_for(input wait_e sel, input string what);
  int unsigned cnt;
  cnt = 0;
  @(negedge clk);
  while (!flag_of(sel) && cnt < wait_limit) begin
    @(negedge clk);
    cnt++;
  end
  if (!flag_of(sel)) begin
    timeouts++;
    $display("timeout: %s", what);
  end
endtask

// OE copy switches on the handshake edge, same as the DUT register
task automatic follow_oe(input logic [axil_addr_w-1:0] addr, input logic [gpio_w-1:0] data);
  if (addr == reg_oe) begin
    tb_oe <= data;
  end
endtask

task automatic axi_write(input logic [axil_addr_w-1:0] addr, input logic [gpio_w-1:0] data);
  @(posedge clk);
  axil_req.awvalid <= 1'b1;
  axil_req.awaddr  <= addr;
  axil_req.wvalid  <= 1'b1;
  axil_req.wdata   <= data;
  axil_req.bready  <= 1'b1;
  wait_for(w_aw, "write address and data were never accepted");
  @(posedge clk);
  axil_req.awvalid <= 1'b0;
  axil_req.wvalid  <= 1'b0;
  follow_oe(addr, data);
  wait_for(w_b, "write response never arrived");
  // OKAY is 2'b00
  check_equal("write response OKAY", pad_w'(2'b00), pad_w'(axil_rsp.bresp));
  @(posedge clk);
  axil_req.bready <= 1'b0;
endtask

task automatic axi_read(input logic [axil_addr_w-1:0] addr, output logic [gpio_w-1:0] data);
  @(posedge clk);
  axil_req.arvalid <= 1'b1;
  axil_req.araddr  <= addr;
  axil_req.rready  <= 1'b1;
  wait_for(w_ar, "read address was never accepted");
  @(posedge clk);
  axil_req.arvalid <= 1'b0;
  wait_for(w_r, "read data never arrived");
  data = axil_rsp.rdata;
  // every read answers OKAY, unmapped ones too
  check_equal("read response OKAY", pad_w'(2'b00), pad_w'(axil_rsp.rresp));
  @(posedge clk);
  axil_req.rready <= 1'b0;
endtask

// write with bready held low, a read of the same address queued behind it
task automatic write_stalled(input logic [axil_addr_w-1:0] addr,
  input logic [gpio_w-1:0] data, input int unsigned hold, output logic [gpio_w-1:0] rdata);
  @(posedge clk);
  axil_req.awvalid <= 1'b1;
  axil_req.awaddr  <= addr;
  axil_req.wvalid  <= 1'b1;
  axil_req.wdata   <= data;
  axil_req.bready  <= 1'b0;
  wait_for(w_aw, "stalled write was never accepted");
  @(posedge clk);
  axil_req.awvalid <= 1'b0;
  axil_req.wvalid  <= 1'b0;
  axil_req.arvalid <= 1'b1;
  axil_req.araddr  <= addr;
  axil_req.rready  <= 1'b1;
  follow_oe(addr, data);
  repeat (hold) begin
    @(negedge clk);
    check_equal("back-pressure bvalid held", pad_w'(1'b1), pad_w'(axil_rsp.bvalid));
    check_equal("back-pressure read blocked", pad_w'(1'b0), pad_w'(axil_rsp.arready));
  end
  @(posedge clk);
  axil_req.bready <= 1'b1;
  // response taken on this edge
  @(posedge clk);
  axil_req.bready <= 1'b0;
  wait_for(w_ar, "read behind the stalled write was never accepted");
  @(posedge clk);
  axil_req.arvalid <= 1'b0;
  wait_for(w_r, "read data behind the stalled write never arrived");
  rdata = axil_rsp.rdata;
  @(posedge clk);
  axil_req.rready <= 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// stimulus table
//////////////////////////////////////////////////////////////////////

function automatic void add_step(input string name, input op_e op,
  input logic [axil_addr_w-1:0] addr, input logic [pad_w-1:0] data,
  input logic [pad_w-1:0] exp);
  step_t s;
  s.name = name;
  s.op   = op;
  s.addr = addr;
  s.data = data;
  s.exp  = exp;
  steps.push_back(s);
endfunction

// expected values come from the register model kept here
function automatic void build_steps();
  logic [pad_w-1:0]  drv;
  logic [pad_w-1:0]  start;
  logic [gpio_w-1:0] m_out;
  logic [gpio_w-1:0] m_oe;
  logic [gpio_w-1:0] m_en;
  logic [gpio_w-1:0] m_stat;
  logic [gpio_w-1:0] clr;
  // reset state, tb pattern on every pad proves the DUT is not driving
  drv = rand_pads();
  add_step("reset irq low", op_irq, '0, '0, '0);
  add_step("reset pad pattern", op_pads, '0, drv, '0);
  add_step("reset pads float", op_pad_check, '0, '0, pad_expect('0, '0, drv));
  add_step("reset OUT", op_read, reg_out, '0, '0);
  add_step("reset OE", op_read, reg_oe, '0, '0);
  add_step("reset IRQ_EN", op_read, reg_irq_en, '0, '0);
  add_step("reset IRQ_STAT", op_read, reg_irq_stat, '0, '0);
  // output drive
  m_out = $urandom;
  m_oe  = $urandom;
  add_step("write OUT", op_write, reg_out, pad_w'(m_out), '0);
  add_step("write OE", op_write, reg_oe, pad_w'(m_oe), '0);
  add_step("pads follow OUT under OE", op_pad_check, '0, '0, pad_expect(m_out, m_oe, drv));
  add_step("readback OUT", op_read, reg_out, '0, pad_w'(m_out));
  add_step("readback OE", op_read, reg_oe, '0, pad_w'(m_oe));
  // input path
  m_oe = '0;
  drv  = rand_pads();
  add_step("OE off", op_write, reg_oe, pad_w'(m_oe), '0);
  add_step("random pad inputs", op_pads, '0, drv, '0);
  add_step("IN follows pads", op_read, reg_in, '0, pad_w'(drv[gpio_w-1:0]));
  add_step("unmapped 0x14", op_read, 8'h14, '0, '0);
  add_step("unmapped 0x40", op_read, 8'h40, '0, '0);
  // edge interrupt, bit 0 always rises and is enabled
  start    = rand_pads();
  start[0] = 1'b0;
  m_en     = $urandom | 32'h1;
  add_step("pads before edges", op_pads, '0, start, '0);
  add_step("clear stale status", op_write, reg_irq_stat, pad_w'(32'hFFFF_FFFF), '0);
  add_step("write IRQ_EN", op_write, reg_irq_en, pad_w'(m_en), '0);
  drv = start;
  drv[gpio_w-1:0] = ~start[gpio_w-1:0];
  m_stat = ~start[gpio_w-1:0] & m_en;
  add_step("toggle pads", op_pads, '0, drv, '0);
  add_step("irq raised", op_irq, '0, pad_w'(1'b1), pad_w'(1'b1));
  add_step("status of enabled risers", op_read, reg_irq_stat, '0, pad_w'(m_stat));
  add_step("readback IRQ_EN", op_read, reg_irq_en, '0, pad_w'(m_en));
  // clear part, then the rest
  clr    = m_stat & $urandom & ~32'h1;
  m_stat = m_stat & ~clr;
  add_step("partial clear", op_write, reg_irq_stat, pad_w'(clr), '0);
  add_step("status after partial clear", op_read, reg_irq_stat, '0, pad_w'(m_stat));
  add_step("irq held by remaining bits", op_irq, '0, pad_w'(1'b1), pad_w'(1'b1));
  add_step("clear the rest", op_write, reg_irq_stat, pad_w'(m_stat), '0);
  add_step("status empty", op_read, reg_irq_stat, '0, '0);
  add_step("irq dropped", op_irq, '0, '0, '0);
  // back-pressure
  m_out = $urandom;
  add_step("read behind held write", op_stall, reg_out, pad_w'(m_out), pad_w'(m_out));
  add_step("OUT after held write", op_read, reg_out, '0, pad_w'(m_out));
endfunction

task automatic run_step(input step_t s);
  logic [gpio_w-1:0] rdata;
  int unsigned       cnt;
  case (s.op)
    op_write: axi_write(s.addr, s.data[gpio_w-1:0]);
    op_read: begin
      axi_read(s.addr, rdata);
      check_equal(s.name, s.exp, pad_w'(rdata));
    end
    // two edges through the synchronizer, one more for the edge detector
    op_pads: begin
      @(posedge clk);
      tb_pad_drv <= s.data;
      repeat (4) @(posedge clk);
    end
    op_pad_check: begin
      @(negedge clk);
      check_equal(s.name, s.exp, pad);
    end
    op_irq: begin
      cnt = 0;
      @(negedge clk);
      while (irq !== s.exp[0] && cnt < wait_limit) begin
        @(negedge clk);
        cnt++;
      end
      if (irq !== s.exp[0]) begin
        timeouts++;
        $display("timeout: irq never reached %b in step %s", s.exp[0], s.name);
      end
      check_equal(s.name, s.exp, pad_w'(irq));
    end
    default: begin
      write_stalled(s.addr, s.data[gpio_w-1:0], 5, rdata);
      check_equal(s.name, s.exp, pad_w'(rdata));
    end
  endcase
endtask

//////////////////////////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////////////////////////

initial begin
  int unsigned assert_fails;
  void'($urandom(32'h3499));
  arst_n     = 1'b0;
  axil_req   = '0;
  tb_pad_drv = '0;
  tb_oe      = '0;
  build_steps();
  repeat (4) @(posedge clk);
  arst_n <= 1'b1;
  // internal reset releases rst_sync_depth edges later
  repeat (rst_sync_depth + 2) @(posedge clk);
  foreach (steps[i]) begin
    run_step(steps[i]);
  end
  repeat (2) @(posedge clk);
  assert_fails = UUT.u_ctrl.u_axil_checks.fail_count;
  $display("steps %0d, checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
    steps.size(), checks, mismatches, timeouts, assert_fails);
  if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
    $display("NO ERRORS");
  end else begin
    $display("ERRORS FOUND");
  end
  $finish;
end

endmodule : gpio_soc_tb

`default_nettype wire

// ==== list.f ====
logic/gpio_pkg.sv
logic/reset_sync.sv
logic/gpio_input_sync.sv
logic/gpio_event_detect.sv
logic/gpio_axil_ctrl.sv
logic/gpio_soc_board.sv
tests/gpio_soc_assertions.sv
tests/gpio_soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the GPIO subsystem testbench with Verilator and run it
# the run passes only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gpio_soc_tb \
  -f list.f --Mdir obj_dir -o gpio_soc_sim \
  && ./obj_dir/gpio_soc_sim | tee /dev/stderr | grep -q "^NO ERRORS$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
exit 0
